//--- logic/alu.sv
`default_nettype none

module alu
	import core_pkg::*;
(
	input  word_t   a,
	input  word_t   b,
	input  shamt_t  shamt,
	input  alu_op_e op,
	output word_t   y,
	output logic    ov
);
	localparam int MSB = $bits(word_t) - 1;

	word_t sum;
	word_t diff;

	// leading run of val from the msb, full width when all bits match
	function automatic word_t lead_cnt(input word_t v, input logic val);
		word_t n;
		logic stop;
		n = '0;
		stop = 1'b0;
		for (int i = MSB; i >= 0; i--) begin
			if (v[i] != val)
				stop = 1'b1;
			if (!stop)
				n = n + 1'b1;
		end
		return n;
	endfunction

	assign sum  = a + b;
	assign diff = a - b;

	always_comb begin
		y  = '0;
		ov = 1'b0;
		case (op)
			ADD: begin
				y  = sum;
				ov = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			SUB: begin
				y  = diff;
				ov = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			SLT:  y = word_t'($signed(a) < $signed(b));
			SLTU: y = word_t'(a < b);
			AND:  y = a & b;
			OR:   y = a | b;
			XOR:  y = a ^ b;
			NOR:  y = ~(a | b);
			SLL:  y = b << shamt;
			SRL:  y = b >> shamt;
			SRA:  y = $signed(b) >>> shamt;
			// variable shifts take the amount from rs
			SLLV: y = b << a[$bits(shamt_t)-1:0];
			SRLV: y = b >> a[$bits(shamt_t)-1:0];
			SRAV: y = $signed(b) >>> a[$bits(shamt_t)-1:0];
			CLO:  y = lead_cnt(a, 1'b1);
			CLZ:  y = lead_cnt(a, 1'b0);
			default: y = '0;
		endcase
	end
endmodule

`default_nettype wire

//--- logic/axil_host_port.sv
`default_nettype none
`include "core_cfg.svh"

module axil_host_port
	import core_pkg::*;
(
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [`CORE_AXI_ADDR_W-1:0]   awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [`CORE_DATA_W-1:0]       wdata,
	input  logic [`CORE_DATA_W/8-1:0]     wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [`CORE_AXI_ADDR_W-1:0]   araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [`CORE_DATA_W-1:0]       rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,
	issue_if.host                         issue
);
	logic        rdy_en;
	logic        wr_hs;
	logic        wr_issue;
	logic        rd_hs;
	logic        rd_status;
	logic        rd_win;
	logic [`CORE_AXI_ADDR_W-1:0] reg_off;
	logic        st_ri;
	logic        st_ov;
	logic [15:0] issue_cnt;
	word_t       status_word;

	// readies come up one cycle out of reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rdy_en <= 1'b0;
		else
			rdy_en <= 1'b1;
	end

	// AW and W are taken together
	assign awready  = rdy_en && awvalid && wvalid && !bvalid;
	assign wready   = awready;
	assign wr_hs    = awready;
	// partial strobes to ISSUE are rejected
	assign wr_issue = (awaddr == `CORE_ADDR_ISSUE) && (wstrb == '1);

	assign issue.valid = wr_hs && wr_issue;
	assign issue.instr = wdata;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			bvalid <= 1'b0;
		else if (wr_hs)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_hs)
			bresp <= (wr_issue && !issue.ri && !issue.ov) ? RESP_OKAY : RESP_SLVERR;
	end

	// sticky until the next issue
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st_ri     <= 1'b0;
			st_ov     <= 1'b0;
			issue_cnt <= '0;
		end else if (issue.valid) begin
			st_ri     <= issue.ri;
			st_ov     <= issue.ov;
			issue_cnt <= issue_cnt + 1'b1;
		end
	end

	assign status_word = {issue_cnt, {($bits(word_t) - 18){1'b0}}, st_ov, st_ri};

	assign arready   = rdy_en && !rvalid;
	assign rd_hs     = arvalid && arready;
	assign rd_status = (araddr == `CORE_ADDR_STATUS);
	assign reg_off   = araddr - `CORE_ADDR_REGS;
	assign rd_win    = (araddr >= `CORE_ADDR_REGS) && (reg_off[1:0] == 2'b00) &&
		((reg_off >> 2) < `CORE_REG_CNT);

	assign issue.rd_idx = reg_off[2 +: $bits(reg_idx_t)];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rvalid <= 1'b0;
		else if (rd_hs)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_hs) begin
			if (rd_status) begin
				rdata <= status_word;
				rresp <= RESP_OKAY;
			end else if (rd_win) begin
				rdata <= issue.rd_data;
				rresp <= RESP_OKAY;
			end else begin
				rdata <= '0;
				rresp <= RESP_SLVERR;
			end
		end
	end
endmodule

`default_nettype wire

//--- logic/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath sizes
`define CORE_DATA_W 32
`define CORE_REG_CNT 32

// AXI4-Lite slave address map
`define CORE_AXI_ADDR_W 8
`define CORE_ADDR_ISSUE 8'h00
`define CORE_ADDR_STATUS 8'h04

// register n sits at base + 4*n
`define CORE_ADDR_REGS 8'h80

`endif

//--- logic/core_pkg.sv
`default_nettype none
`include "core_cfg.svh"

package core_pkg;

	typedef logic [`CORE_DATA_W-1:0] word_t;
	typedef logic [$clog2(`CORE_REG_CNT)-1:0] reg_idx_t;
	typedef logic [$clog2(`CORE_DATA_W)-1:0] shamt_t;
	typedef logic [5:0] opcode_t;

	typedef enum logic [3:0] {
		ADD, SUB, SLT, SLTU, AND, OR, XOR, NOR,
		SLL, SRL, SRA, SLLV, SRLV, SRAV, CLO, CLZ
	} alu_op_e;

	typedef enum logic [1:0] {EXT_SIGNED, EXT_UNSIGNED, EXT_LUI} ext_op_e;
	typedef enum logic [1:0] {WD_ALU, WD_EXT, WD_RS} wd_sel_e;
	typedef enum logic [1:0] {CMP_NONE, CMP_RTEZ, CMP_RTNEZ} cmp_op_e;
	typedef enum logic {B_RT, B_EXT} alu_b_sel_e;

	// major opcodes
	localparam opcode_t OP_SP    = 6'h00;
	localparam opcode_t OP_SP2   = 6'h1c;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_ADDIU = 6'h09;
	localparam opcode_t OP_SLTI  = 6'h0a;
	localparam opcode_t OP_SLTIU = 6'h0b;
	localparam opcode_t OP_ANDI  = 6'h0c;
	localparam opcode_t OP_ORI   = 6'h0d;
	localparam opcode_t OP_XORI  = 6'h0e;
	localparam opcode_t OP_LUI   = 6'h0f;

	// funct under SPECIAL
	localparam opcode_t FN_SLL  = 6'h00;
	localparam opcode_t FN_SRL  = 6'h02;
	localparam opcode_t FN_SRA  = 6'h03;
	localparam opcode_t FN_SLLV = 6'h04;
	localparam opcode_t FN_SRLV = 6'h06;
	localparam opcode_t FN_SRAV = 6'h07;
	localparam opcode_t FN_MOVZ = 6'h0a;
	localparam opcode_t FN_MOVN = 6'h0b;
	localparam opcode_t FN_ADD  = 6'h20;
	localparam opcode_t FN_ADDU = 6'h21;
	localparam opcode_t FN_SUB  = 6'h22;
	localparam opcode_t FN_SUBU = 6'h23;
	localparam opcode_t FN_AND  = 6'h24;
	localparam opcode_t FN_OR   = 6'h25;
	localparam opcode_t FN_XOR  = 6'h26;
	localparam opcode_t FN_NOR  = 6'h27;
	localparam opcode_t FN_SLT  = 6'h2a;
	localparam opcode_t FN_SLTU = 6'h2b;

	// funct under SPECIAL2
	localparam opcode_t FN_CLZ = 6'h20;
	localparam opcode_t FN_CLO = 6'h21;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- logic/core_top.sv
`default_nettype none
`include "core_cfg.svh"

module core_top
	import core_pkg::*;
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [`CORE_AXI_ADDR_W-1:0] awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`CORE_DATA_W-1:0]     wdata,
	input  logic [`CORE_DATA_W/8-1:0]   wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`CORE_AXI_ADDR_W-1:0] araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [`CORE_DATA_W-1:0]     rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready
);
	reg_idx_t    rs, rt, rf_a3, wa;
	shamt_t      shamt;
	logic [15:0] imm16;
	alu_op_e     alu_op;
	ext_op_e     ext_op;
	alu_b_sel_e  alu_b_sel;
	cmp_op_e     cmp_op;
	wd_sel_e     wd_sel;
	logic        rf_wr, ov_en, we;
	word_t       rs_val, rt_val, wd;

	issue_if issue ();

	axil_host_port u_host (
		.clk, .arst_n,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.issue (issue.host)
	);

	instr_decode u_dec (
		.instr (issue.instr), .rs, .rt, .rd (), .shamt, .imm16,
		.alu_op, .ext_op, .alu_b_sel, .cmp_op, .wd_sel,
		.rf_wr, .rf_a3, .ov_en, .ri (issue.ri)
	);

	reg_file u_rf (
		.clk, .arst_n,
		.ra1 (rs), .ra2 (rt), .ra3 (issue.rd_idx),
		.rd1 (rs_val), .rd2 (rt_val), .rd3 (issue.rd_data),
		.we, .wa, .wd
	);

	exec_unit u_ex (
		.valid (issue.valid), .shamt, .imm16,
		.alu_op, .ext_op, .alu_b_sel, .cmp_op, .wd_sel,
		.rf_wr, .rf_a3, .ov_en, .ri (issue.ri),
		.rs_val, .rt_val, .we, .wa, .wd, .ov (issue.ov)
	);
endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`default_nettype none

module exec_unit
	import core_pkg::*;
(
	input  logic        valid,
	input  shamt_t      shamt,
	input  logic [15:0] imm16,
	input  alu_op_e     alu_op,
	input  ext_op_e     ext_op,
	input  alu_b_sel_e  alu_b_sel,
	input  cmp_op_e     cmp_op,
	input  wd_sel_e     wd_sel,
	input  logic        rf_wr,
	input  reg_idx_t    rf_a3,
	input  logic        ov_en,
	input  logic        ri,
	input  word_t       rs_val,
	input  word_t       rt_val,
	output logic        we,
	output reg_idx_t    wa,
	output word_t       wd,
	output logic        ov
);
	localparam int PAD = $bits(word_t) - 16;

	word_t ext_val;
	word_t alu_b;
	word_t alu_y;
	logic  alu_ov;
	logic  cond;

	always_comb begin
		case (ext_op)
			EXT_SIGNED: ext_val = {{PAD{imm16[15]}}, imm16};
			EXT_LUI:    ext_val = {imm16, {PAD{1'b0}}};
			default:    ext_val = {{PAD{1'b0}}, imm16};
		endcase
	end

	assign alu_b = (alu_b_sel == B_EXT) ? ext_val : rt_val;

	alu u_alu (
		.a     (rs_val),
		.b     (alu_b),
		.shamt (shamt),
		.op    (alu_op),
		.y     (alu_y),
		.ov    (alu_ov)
	);

	// movz / movn condition on rt
	always_comb begin
		case (cmp_op)
			CMP_RTEZ:  cond = (rt_val == '0);
			CMP_RTNEZ: cond = (rt_val != '0);
			default:   cond = 1'b1;
		endcase
	end

	always_comb begin
		case (wd_sel)
			WD_EXT:  wd = ext_val;
			WD_RS:   wd = rs_val;
			default: wd = alu_y;
		endcase
	end

	assign ov = ov_en && alu_ov;
	// exceptions kill the writeback
	assign we = valid && rf_wr && cond && !ov && !ri;
	assign wa = rf_a3;
endmodule

`default_nettype wire

//--- logic/instr_decode.sv
`default_nettype none

module instr_decode
	import core_pkg::*;
(
	input  word_t       instr,
	output reg_idx_t    rs,
	output reg_idx_t    rt,
	output reg_idx_t    rd,
	output shamt_t      shamt,
	output logic [15:0] imm16,
	output alu_op_e     alu_op,
	output ext_op_e     ext_op,
	output alu_b_sel_e  alu_b_sel,
	output cmp_op_e     cmp_op,
	output wd_sel_e     wd_sel,
	output logic        rf_wr,
	output reg_idx_t    rf_a3,
	output logic        ov_en,
	output logic        ri
);
	opcode_t op;
	opcode_t funct;
	logic sp, sp2;
	logic is_addi, is_addiu, is_andi, is_ori, is_xori, is_slti, is_sltiu, is_lui;
	logic is_add, is_addu, is_sub, is_subu, is_and, is_or, is_xor, is_nor;
	logic is_slt, is_sltu, is_sll, is_srl, is_sra, is_sllv, is_srlv, is_srav;
	logic is_clo, is_clz, is_movz, is_movn;
	logic cali, calr, shifts, mov;

	assign op    = instr[31:26];
	assign funct = instr[5:0];
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];
	assign shamt = instr[10:6];
	assign imm16 = instr[15:0];

	assign sp  = (op == OP_SP);
	assign sp2 = (op == OP_SP2);

	assign is_addi  = (op == OP_ADDI);
	assign is_addiu = (op == OP_ADDIU);
	assign is_andi  = (op == OP_ANDI);
	assign is_ori   = (op == OP_ORI);
	assign is_xori  = (op == OP_XORI);
	assign is_slti  = (op == OP_SLTI);
	assign is_sltiu = (op == OP_SLTIU);
	assign is_lui   = (op == OP_LUI);

	assign is_add  = sp && (funct == FN_ADD);
	assign is_addu = sp && (funct == FN_ADDU);
	assign is_sub  = sp && (funct == FN_SUB);
	assign is_subu = sp && (funct == FN_SUBU);
	assign is_and  = sp && (funct == FN_AND);
	assign is_or   = sp && (funct == FN_OR);
	assign is_xor  = sp && (funct == FN_XOR);
	assign is_nor  = sp && (funct == FN_NOR);
	assign is_slt  = sp && (funct == FN_SLT);
	assign is_sltu = sp && (funct == FN_SLTU);
	// all-zero word lands here as sll r0, a plain nop
	assign is_sll  = sp && (funct == FN_SLL);
	assign is_srl  = sp && (funct == FN_SRL);
	assign is_sra  = sp && (funct == FN_SRA);
	assign is_sllv = sp && (funct == FN_SLLV);
	assign is_srlv = sp && (funct == FN_SRLV);
	assign is_srav = sp && (funct == FN_SRAV);
	assign is_movz = sp && (funct == FN_MOVZ);
	assign is_movn = sp && (funct == FN_MOVN);
	assign is_clo  = sp2 && (funct == FN_CLO);
	assign is_clz  = sp2 && (funct == FN_CLZ);

	assign cali   = is_addi | is_addiu | is_andi | is_ori | is_xori | is_slti | is_sltiu;
	assign shifts = is_sll | is_srl | is_sra;
	assign calr   = is_add | is_addu | is_sub | is_subu | is_and | is_or | is_xor | is_nor |
		is_slt | is_sltu | shifts | is_sllv | is_srlv | is_srav | is_clo | is_clz;
	assign mov    = is_movz | is_movn;

	assign ri    = !(cali | calr | is_lui | mov);
	assign ov_en = is_add | is_addi | is_sub;

	always_comb begin
		if (is_sub || is_subu) alu_op = SUB;
		else if (is_slt || is_slti) alu_op = SLT;
		else if (is_sltu || is_sltiu) alu_op = SLTU;
		else if (is_nor) alu_op = NOR;
		else if (is_or || is_ori) alu_op = OR;
		else if (is_xor || is_xori) alu_op = XOR;
		else if (is_and || is_andi) alu_op = AND;
		else if (is_sll) alu_op = SLL;
		else if (is_sra) alu_op = SRA;
		else if (is_srl) alu_op = SRL;
		else if (is_sllv) alu_op = SLLV;
		else if (is_srav) alu_op = SRAV;
		else if (is_srlv) alu_op = SRLV;
		else if (is_clo) alu_op = CLO;
		else if (is_clz) alu_op = CLZ;
		else alu_op = ADD;
	end

	assign ext_op = (is_addi || is_addiu || is_slti || is_sltiu) ? EXT_SIGNED :
		is_lui ? EXT_LUI : EXT_UNSIGNED;

	assign alu_b_sel = (cali || is_lui) ? B_EXT : B_RT;

	assign cmp_op = is_movz ? CMP_RTEZ :
		is_movn ? CMP_RTNEZ : CMP_NONE;

	assign wd_sel = is_lui ? WD_EXT :
		mov ? WD_RS : WD_ALU;

	// moves request unconditionally, the exec unit applies the condition
	assign rf_wr = cali | calr | is_lui | mov;

	assign rf_a3 = (cali || is_lui) ? rt :
		(calr || mov) ? rd : '0;
endmodule

`default_nettype wire

//--- logic/issue_if.sv
`default_nettype none

interface issue_if
	import core_pkg::*;
();
	logic     valid;
	word_t    instr;
	reg_idx_t rd_idx;
	word_t    rd_data;
	logic     ri;
	logic     ov;

	modport host (
		output valid, instr, rd_idx,
		input  rd_data, ri, ov
	);

	// datapath side
	modport core (
		input  valid, instr, rd_idx,
		output rd_data, ri, ov
	);
endinterface

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none
`include "core_cfg.svh"

module reg_file
	import core_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t ra1,
	input  reg_idx_t ra2,
	input  reg_idx_t ra3,
	output word_t    rd1,
	output word_t    rd2,
	output word_t    rd3,
	input  logic     we,
	input  reg_idx_t wa,
	input  word_t    wd
);
	// r0 has no storage
	word_t regs [1:`CORE_REG_CNT-1];

	function automatic word_t rd_port(input reg_idx_t a);
		return (a == '0) ? '0 : regs[a];
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = rd_port(ra1);
	assign rd2 = rd_port(ra2);
	// host window
	assign rd3 = rd_port(ra3);
endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/core_pkg.sv
logic/issue_if.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/exec_unit.sv
logic/axil_host_port.sv
logic/core_top.sv
tb/core_sva.sv
tb/core_tb.sv

//--- tb/core_sva.sv
`default_nettype none

module core_sva (
	input logic clk,
	input logic arst_n,
	input logic awready,
	input logic wready,
	input logic arready,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready
);
	timeunit 1ns;
	timeprecision 100ps;

	int fails = 0;

	bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid)
	else begin
		fails++;
		$error("bvalid dropped before bready");
	end

	rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid)
	else begin
		fails++;
		$error("rvalid dropped before rready");
	end

	// no new write accepted while a response waits
	write_backpressure: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid |-> !awready && !wready)
	else begin
		fails++;
		$error("write ready high while bvalid is pending");
	end

	quiet_in_reset: assert property (@(posedge clk)
		!arst_n |-> !awready && !wready && !arready)
	else begin
		fails++;
		$error("ready output high during reset");
	end
endmodule

bind core_top core_sva u_sva (
	.clk, .arst_n, .awready, .wready, .arready,
	.bvalid, .bready, .rvalid, .rready
);

`default_nettype wire

//--- tb/core_tb.sv
`default_nettype none
`include "core_cfg.svh"

module core_tb
	import core_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TMO = 50;
	localparam opcode_t R_FNS [8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
		FN_SLT, FN_SLTU};
	localparam opcode_t I_OPS [5] = '{OP_ANDI, OP_XORI, OP_SLTI, OP_SLTIU, OP_ADDIU};
	localparam opcode_t S_FNS [6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};

	logic clk;
	logic arst_n;
	logic [`CORE_AXI_ADDR_W-1:0] awaddr;
	logic [`CORE_AXI_ADDR_W-1:0] araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [`CORE_DATA_W-1:0] wdata;
	logic [`CORE_DATA_W-1:0] rdata;
	logic [`CORE_DATA_W/8-1:0] wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;

	// reference model state
	word_t rf [32];
	logic st_ri;
	logic st_ov;
	logic [15:0] cnt;
	int errors;
	int timeouts;

	core_top DUT (.*);

	always #2 clk = ~clk;

	task automatic finish_run();
		int sva_fails;
		sva_fails = DUT.u_sva.fails;
		$display("checks failed: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, sva_fails);
		if (errors == 0 && timeouts == 0 && sva_fails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	task automatic give_up(input string what);
		timeouts++;
		$display("timeout waiting for %s", what);
		finish_run();
	endtask

	task automatic check(input string name, input word_t exp, input word_t act);
		assert (act === exp)
		else begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// starts and ends 1 ns after a rising edge
	task automatic axi_write(input logic [7:0] addr, input word_t data, input logic keep,
			output logic [1:0] resp);
		int t;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!(awready && wready) && t < TMO);
		if (!(awready && wready))
			give_up("awready and wready");
		@(posedge clk);
		#1;
		// with keep the next write stays offered while this response waits
		if (!keep) begin
			awvalid = 1'b0;
			wvalid = 1'b0;
		end
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!bvalid && t < TMO);
		if (!bvalid)
			give_up("bvalid");
		resp = bresp;
		// response held for a cycle before it is taken
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output word_t data, output logic [1:0] resp);
		int t;
		araddr = addr;
		arvalid = 1'b1;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!arready && t < TMO);
		if (!arready)
			give_up("arready");
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!rvalid && t < TMO);
		if (!rvalid)
			give_up("rvalid");
		data = rdata;
		resp = rresp;
		// read data held for a cycle before it is taken
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	function automatic word_t rtype(opcode_t op, opcode_t fn, reg_idx_t rs, reg_idx_t rt,
			reg_idx_t rd, shamt_t sa);
		return {op, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t itype(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t lead(input word_t v, input logic one);
		int n;
		n = 0;
		while (n < 32 && v[31 - n] == one)
			n++;
		return n;
	endfunction

	// expected effect of one instruction on the model registers
	function automatic void model_exec(input word_t ins, output reg_idx_t dst,
			output word_t val, output logic wr, output logic ri, output logic ov);
		opcode_t op;
		opcode_t fn;
		word_t a;
		word_t b;
		word_t se;
		logic [32:0] s;
		int sa;
		op = ins[31:26];
		fn = ins[5:0];
		a = rf[ins[25:21]];
		b = rf[ins[20:16]];
		se = {{16{ins[15]}}, ins[15:0]};
		sa = ins[10:6];
		dst = (op == OP_SP || op == OP_SP2) ? ins[15:11] : ins[20:16];
		val = '0;
		wr = 1'b1;
		ri = 1'b0;
		ov = 1'b0;
		case (op)
			OP_SP: case (fn)
				FN_SLL: val = b << sa;
				FN_SRL: val = b >> sa;
				FN_SRA: val = word_t'($signed(b) >>> sa);
				FN_SLLV: val = b << a[4:0];
				FN_SRLV: val = b >> a[4:0];
				FN_SRAV: val = word_t'($signed(b) >>> a[4:0]);
				FN_MOVZ: begin
					val = a;
					wr = (b == 0);
				end
				FN_MOVN: begin
					val = a;
					wr = (b != 0);
				end
				FN_ADD, FN_ADDU: begin
					s = {a[31], a} + {b[31], b};
					val = s[31:0];
					ov = (fn == FN_ADD) && (s[32] != s[31]);
				end
				FN_SUB, FN_SUBU: begin
					s = {a[31], a} - {b[31], b};
					val = s[31:0];
					ov = (fn == FN_SUB) && (s[32] != s[31]);
				end
				FN_AND: val = a & b;
				FN_OR: val = a | b;
				FN_XOR: val = a ^ b;
				FN_NOR: val = ~(a | b);
				FN_SLT: val = ($signed(a) < $signed(b)) ? 1 : 0;
				FN_SLTU: val = (a < b) ? 1 : 0;
				default: ri = 1'b1;
			endcase
			OP_SP2: case (fn)
				FN_CLO: val = lead(a, 1'b1);
				FN_CLZ: val = lead(a, 1'b0);
				default: ri = 1'b1;
			endcase
			OP_ADDI, OP_ADDIU: begin
				s = {a[31], a} + {se[31], se};
				val = s[31:0];
				ov = (op == OP_ADDI) && (s[32] != s[31]);
			end
			OP_SLTI: val = ($signed(a) < $signed(se)) ? 1 : 0;
			OP_SLTIU: val = (a < se) ? 1 : 0;
			OP_ANDI: val = a & {16'h0, ins[15:0]};
			OP_ORI: val = a | {16'h0, ins[15:0]};
			OP_XORI: val = a ^ {16'h0, ins[15:0]};
			OP_LUI: val = {ins[15:0], 16'h0};
			default: ri = 1'b1;
		endcase
		if (ri || ov)
			wr = 1'b0;
	endfunction

	// issue one word, check the response and read back its destination
	task automatic exec(input string name, input word_t ins);
		reg_idx_t dst;
		word_t val;
		word_t got;
		logic wr, ri, ov;
		logic [1:0] resp;
		model_exec(ins, dst, val, wr, ri, ov);
		axi_write(`CORE_ADDR_ISSUE, ins, 1'b0, resp);
		check({name, " bresp"}, (ri || ov) ? RESP_SLVERR : RESP_OKAY, resp);
		if (wr && dst != 0)
			rf[dst] = val;
		st_ri = ri;
		st_ov = ov;
		cnt++;
		axi_read(8'(`CORE_ADDR_REGS + 4 * dst), got, resp);
		check(name, rf[dst], got);
		check({name, " rresp"}, RESP_OKAY, resp);
	endtask

	task automatic load(input reg_idx_t r, input word_t v);
		exec("lui", itype(OP_LUI, 0, r, v[31:16]));
		exec("ori", itype(OP_ORI, r, r, v[15:0]));
	endtask

	task automatic check_all(input string name);
		word_t got;
		logic [1:0] resp;
		for (int i = 0; i < 32; i++) begin
			axi_read(8'(`CORE_ADDR_REGS + 4 * i), got, resp);
			check($sformatf("%s r%0d", name, i), rf[i], got);
			check($sformatf("%s r%0d rresp", name, i), RESP_OKAY, resp);
		end
		axi_read(`CORE_ADDR_STATUS, got, resp);
		check({name, " status"}, {cnt, 14'h0, st_ov, st_ri}, got);
		check({name, " status rresp"}, RESP_OKAY, resp);
	endtask

	initial begin
		reg_idx_t rs;
		reg_idx_t rt;
		logic [1:0] resp;
		void'($urandom(65103));
		clk = 1'b0;
		arst_n = 1'b0;
		awaddr = '0;
		araddr = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '1;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		rf = '{default: '0};
		st_ri = 1'b0;
		st_ov = 1'b0;
		cnt = '0;
		errors = 0;
		timeouts = 0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;

		check_all("reset");
		exec("r0_write", itype(OP_ADDIU, 0, 0, 16'h1234));

		for (int r = 1; r <= 8; r++)
			load(r, $urandom);
		check_all("const");

		for (int i = 0; i < 40; i++) begin
			rs = $urandom_range(0, 8);
			rt = $urandom_range(0, 8);
			if ($urandom_range(0, 1))
				exec("calr", rtype(OP_SP, R_FNS[$urandom_range(0, 7)], rs, rt,
					$urandom_range(1, 15), 0));
			else
				exec("cali", itype(I_OPS[$urandom_range(0, 4)], rs,
					$urandom_range(1, 15), 16'($urandom)));
		end

		// all ones, zero and a random word as shift and count sources
		load(20, '1);
		exec("zero", rtype(OP_SP, FN_ADDU, 0, 0, 21, 0));
		load(22, $urandom);
		for (int s = 20; s <= 22; s++) begin
			for (int k = 0; k < 6; k++)
				exec("shift", rtype(OP_SP, S_FNS[k], $urandom_range(20, 22), s, 30,
					$urandom_range(0, 31)));
			exec("clo", rtype(OP_SP2, FN_CLO, s, 0, 30, 0));
			exec("clz", rtype(OP_SP2, FN_CLZ, s, 0, 30, 0));
		end

		exec("zero", rtype(OP_SP, FN_ADDU, 0, 0, 23, 0));
		load(24, $urandom | 32'h1);
		for (int m = 0; m < 4; m++) begin
			load(25, $urandom);
			exec("move", rtype(OP_SP, (m < 2) ? FN_MOVZ : FN_MOVN, 22, (m % 2) ? 24 : 23,
				25, 0));
		end
		check_all("move");

		exec("reserved_op", {6'h3f, 26'($urandom)});
		check_all("reserved_op");
		exec("reserved_fn", rtype(OP_SP, 6'h01, 1, 2, 3, 0));
		check_all("reserved_fn");
		load(26, 32'h7fff_ffff);
		load(28, 32'h8000_0000);
		exec("add_ov", rtype(OP_SP, FN_ADD, 26, 26, 27, 0));
		check_all("add_ov");
		exec("addi_ov", itype(OP_ADDI, 26, 27, 16'h0001));
		check_all("addi_ov");
		exec("sub_ov", rtype(OP_SP, FN_SUB, 28, 26, 27, 0));
		check_all("sub_ov");
		exec("clear", rtype(OP_SP, FN_ADDU, 26, 28, 27, 0));
		check_all("clear");

		// second nop offered while the first response waits
		axi_write(`CORE_ADDR_ISSUE, '0, 1'b1, resp);
		check("busy_first bresp", RESP_OKAY, resp);
		axi_write(`CORE_ADDR_ISSUE, '0, 1'b0, resp);
		check("busy_second bresp", RESP_OKAY, resp);
		cnt = cnt + 16'd2;
		check_all("busy");

		finish_run();
	end
endmodule

`default_nettype wire
